//--- src/dma_arb_pkg.sv
package dma_arb_pkg;

    // region count and the width of a region number.
    localparam int N_REGIONS      = 4;
    localparam int N_REGIONS_BITS = 2;

    localparam int ADDR_BITS = 48;  // physical address width on both sides.
    localparam int LEN_BITS  = 28;  // transfer length in bytes.

    // outstanding completions that can wait for their done.
    localparam int CPL_DEPTH = 8;

    // register map of the control block.
    localparam int REG_ADDR_BITS = 2;
    localparam logic [REG_ADDR_BITS-1:0] REG_ENABLE = 2'd0;
    localparam logic [REG_ADDR_BITS-1:0] REG_GRANTS = 2'd1;
    localparam logic [REG_ADDR_BITS-1:0] REG_CPLS   = 2'd2;

    // descriptor presented by a user region.
    // it carries both addresses, the arbiter splits them per channel.
    typedef struct packed {
        logic [ADDR_BITS-1:0] paddr_host;
        logic [ADDR_BITS-1:0] paddr_card;
        logic [LEN_BITS-1:0]  len;
        logic                 ctl;  // request a completion for this transfer.
    } dma_req_t;

    // descriptor as seen by a single channel.
    typedef struct packed {
        logic [ADDR_BITS-1:0] paddr;
        logic [LEN_BITS-1:0]  len;
        logic                 ctl;
    } dma_chan_req_t;

    // register access from software.
    typedef struct packed {
        logic                     wr;     // 1 for a write, 0 for a read.
        logic [REG_ADDR_BITS-1:0] addr;
        logic [31:0]              wdata;
    } reg_req_t;

    // read data returned one cycle after the read.
    typedef struct packed {
        logic [31:0] rdata;
    } reg_rsp_t;

endpackage

//--- src/cpl_queue.sv
`timescale 1ns/1ps

module cpl_queue (
    input  logic                                  aclk,
    input  logic                                  aresetn,
    input  logic                                  push,
    input  logic [dma_arb_pkg::N_REGIONS_BITS-1:0] push_id,
    output logic                                  full,
    input  logic                                  pop,
    output logic [dma_arb_pkg::N_REGIONS_BITS-1:0] head_id,
    output logic                                  empty
);

    logic [dma_arb_pkg::N_REGIONS_BITS-1:0] mem [dma_arb_pkg::CPL_DEPTH];
    logic [$clog2(dma_arb_pkg::CPL_DEPTH)-1:0] wr_ptr;
    logic [$clog2(dma_arb_pkg::CPL_DEPTH)-1:0] rd_ptr;
    logic [$clog2(dma_arb_pkg::CPL_DEPTH):0]   count;  // one bit wider to hold a full queue.

    assign full    = (count == dma_arb_pkg::CPL_DEPTH);
    assign empty   = (count == '0);
    assign head_id = mem[rd_ptr];  // oldest region waiting for its done.

    // a push writes its region number at the tail.
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= push_id;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == dma_arb_pkg::CPL_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == dma_arb_pkg::CPL_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // a push and a pop in the same cycle leave the count as it is.
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn) !(push && full))
        else $error("cpl_queue: push while full");
    assert property (@(posedge aclk) disable iff (!aresetn) !(pop && empty))
        else $error("cpl_queue: pop while empty");

endmodule

//--- src/dma_rr_arbiter.sv
`timescale 1ns/1ps

module dma_rr_arbiter #(
    parameter int rd_wr = 0  // 0 takes completions from the card channel, 1 from the host.
) (
    input  logic                                 aclk,
    input  logic                                 aresetn,

    input  logic [dma_arb_pkg::N_REGIONS-1:0]    region_valid,
    output logic [dma_arb_pkg::N_REGIONS-1:0]    region_ready,
    output logic [dma_arb_pkg::N_REGIONS-1:0]    region_done,
    input  dma_arb_pkg::dma_req_t [dma_arb_pkg::N_REGIONS-1:0] region_req,
    input  logic [dma_arb_pkg::N_REGIONS-1:0]    region_en,

    output logic                                 host_valid,
    output dma_arb_pkg::dma_chan_req_t           host_req,
    input  logic                                 host_ready,
    input  logic                                 host_done,
    output logic                                 card_valid,
    output dma_arb_pkg::dma_chan_req_t           card_req,
    input  logic                                 card_ready,
    input  logic                                 card_done,

    output logic                                 grant_pulse,
    output logic                                 cpl_pulse
);

    logic [dma_arb_pkg::N_REGIONS_BITS-1:0] rr;
    logic [dma_arb_pkg::N_REGIONS_BITS-1:0] win_id;
    logic                                   win_valid;
    logic [dma_arb_pkg::N_REGIONS-1:0]      req_active;
    dma_arb_pkg::dma_req_t                  win_req;
    logic                                   chan_ready;
    logic                                   accept;
    logic                                   done_sel;
    logic                                   q_push;
    logic                                   q_full;
    logic                                   q_pop;
    logic                                   q_empty;
    logic [dma_arb_pkg::N_REGIONS_BITS-1:0] q_head;
    logic [dma_arb_pkg::N_REGIONS-1:0]      done_next;
    logic [dma_arb_pkg::N_REGIONS-1:0]      done_r;

    assign req_active = region_valid & region_en;  // disabled regions never compete.
    assign chan_ready = host_ready & card_ready;
    assign done_sel   = (rd_wr == 0) ? card_done : host_done;

    // search upward from rr and wrap, the first active region wins.
    always_comb begin
        int  idx;
        logic found;
        found  = 1'b0;
        win_id = rr;
        for (int i = 0; i < dma_arb_pkg::N_REGIONS; i++) begin
            idx = (int'(rr) + i) % dma_arb_pkg::N_REGIONS;
            if (!found && req_active[idx]) begin
                found  = 1'b1;
                win_id = idx[dma_arb_pkg::N_REGIONS_BITS-1:0];
            end
        end
        win_valid = found;
    end

    // nothing is offered unless both channels can take it and a queue slot is free.
    assign accept     = win_valid && chan_ready && !q_full;
    assign host_valid = accept;
    assign card_valid = accept;
    assign win_req    = region_req[win_id];

    assign host_req.paddr = win_req.paddr_host;
    assign host_req.len   = win_req.len;
    assign host_req.ctl   = win_req.ctl;
    assign card_req.paddr = win_req.paddr_card;
    assign card_req.len   = win_req.len;
    assign card_req.ctl   = win_req.ctl;

    always_comb begin
        region_ready = '0;
        done_next    = '0;
        if (accept) begin
            region_ready[win_id] = 1'b1;
        end
        if (q_pop) begin
            done_next[q_head] = 1'b1;  // route the done to the oldest waiting region.
        end
    end

    assign q_push      = accept && win_req.ctl;
    assign q_pop       = done_sel && !q_empty;
    assign grant_pulse = accept;
    assign cpl_pulse   = q_pop;
    assign region_done = done_r;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rr     <= '0;
            done_r <= '0;
        end else begin
            // rr steps by one per transfer, whichever region actually won.
            if (accept) begin
                rr <= (rr == dma_arb_pkg::N_REGIONS - 1) ? '0 : rr + 1'b1;
            end
            done_r <= done_next;
        end
    end

    cpl_queue cpl_queue_inst (
        .aclk    (aclk),
        .aresetn (aresetn),
        .push    (q_push),
        .push_id (win_id),
        .full    (q_full),
        .pop     (q_pop),
        .head_id (q_head),
        .empty   (q_empty)
    );

    // both channels must see one and the same transfer.
    assert property (@(posedge aclk) disable iff (!aresetn) host_valid == card_valid)
        else $error("dma_rr_arbiter: host and card channels out of step");

    // a channel done with nothing outstanding means the channel lost track.
    assert property (@(posedge aclk) disable iff (!aresetn) done_sel |-> !q_empty)
        else $error("dma_rr_arbiter: completion without an outstanding request");

endmodule

//--- src/dma_arb_regs.sv
`timescale 1ns/1ps

module dma_arb_regs (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic                              reg_valid,
    output logic                              reg_ready,
    input  dma_arb_pkg::reg_req_t             reg_req,
    output logic                              rsp_valid,
    output dma_arb_pkg::reg_rsp_t             reg_rsp,
    input  logic                              grant_pulse,
    input  logic                              cpl_pulse,
    output logic [dma_arb_pkg::N_REGIONS-1:0] region_en
);

    logic        reg_fire;
    logic        reg_wr;
    logic        reg_rd;
    logic [31:0] grant_cnt;
    logic [31:0] cpl_cnt;
    logic [31:0] rd_data;

    assign reg_fire = reg_valid && reg_ready;
    assign reg_wr   = reg_fire && reg_req.wr;
    assign reg_rd   = reg_fire && !reg_req.wr;

    // unmapped addresses read as zero.
    always_comb begin
        case (reg_req.addr)
            dma_arb_pkg::REG_ENABLE: rd_data = 32'(region_en);
            dma_arb_pkg::REG_GRANTS: rd_data = grant_cnt;
            dma_arb_pkg::REG_CPLS:   rd_data = cpl_cnt;
            default:                 rd_data = '0;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            reg_ready <= 1'b0;
            rsp_valid <= 1'b0;
            region_en <= '1;  // every region may compete out of reset.
            grant_cnt <= '0;
            cpl_cnt   <= '0;
        end else begin
            reg_ready <= 1'b1;
            rsp_valid <= reg_rd;

            if (reg_wr && reg_req.addr == dma_arb_pkg::REG_ENABLE) begin
                region_en <= reg_req.wdata[dma_arb_pkg::N_REGIONS-1:0];
            end

            // a write clears the counter, and the clear beats an event in the same cycle.
            if (reg_wr && reg_req.addr == dma_arb_pkg::REG_GRANTS) begin
                grant_cnt <= '0;
            end else if (grant_pulse) begin
                grant_cnt <= grant_cnt + 1'b1;  // wraps at 32 bits.
            end

            if (reg_wr && reg_req.addr == dma_arb_pkg::REG_CPLS) begin
                cpl_cnt <= '0;
            end else if (cpl_pulse) begin
                cpl_cnt <= cpl_cnt + 1'b1;
            end
        end
    end

    // read data is captured with the request.
    always_ff @(posedge aclk) begin
        if (reg_rd) begin
            reg_rsp.rdata <= rd_data;
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        rsp_valid |-> $past(reg_valid && reg_ready && !reg_req.wr))
        else $error("dma_arb_regs: response without a read");

endmodule

//--- src/dma_arb_top.sv
`timescale 1ns/1ps

module dma_arb_top #(
    parameter int rd_wr = 0
) (
    input  logic                                 aclk,
    input  logic                                 aresetn,

    input  logic [dma_arb_pkg::N_REGIONS-1:0]    region_valid,
    output logic [dma_arb_pkg::N_REGIONS-1:0]    region_ready,
    output logic [dma_arb_pkg::N_REGIONS-1:0]    region_done,
    input  dma_arb_pkg::dma_req_t [dma_arb_pkg::N_REGIONS-1:0] region_req,

    output logic                                 host_valid,
    output dma_arb_pkg::dma_chan_req_t           host_req,
    input  logic                                 host_ready,
    input  logic                                 host_done,
    output logic                                 card_valid,
    output dma_arb_pkg::dma_chan_req_t           card_req,
    input  logic                                 card_ready,
    input  logic                                 card_done,

    input  logic                                 reg_valid,
    output logic                                 reg_ready,
    input  dma_arb_pkg::reg_req_t                reg_req,
    output logic                                 rsp_valid,
    output dma_arb_pkg::reg_rsp_t                reg_rsp
);

    logic [dma_arb_pkg::N_REGIONS-1:0] region_en;
    logic                              grant_pulse;  // one per accepted transfer.
    logic                              cpl_pulse;    // one per routed completion.

    dma_arb_regs dma_arb_regs_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .reg_valid   (reg_valid),
        .reg_ready   (reg_ready),
        .reg_req     (reg_req),
        .rsp_valid   (rsp_valid),
        .reg_rsp     (reg_rsp),
        .grant_pulse (grant_pulse),
        .cpl_pulse   (cpl_pulse),
        .region_en   (region_en)
    );

    dma_rr_arbiter #(
        .rd_wr (rd_wr)
    ) dma_rr_arbiter_inst (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .region_valid (region_valid),
        .region_ready (region_ready),
        .region_done  (region_done),
        .region_req   (region_req),
        .region_en    (region_en),
        .host_valid   (host_valid),
        .host_req     (host_req),
        .host_ready   (host_ready),
        .host_done    (host_done),
        .card_valid   (card_valid),
        .card_req     (card_req),
        .card_ready   (card_ready),
        .card_done    (card_done),
        .grant_pulse  (grant_pulse),
        .cpl_pulse    (cpl_pulse)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;  // 20 ns period.
    end

    // reset is held for ten rising edges and released on a falling edge.
    initial begin
        aresetn = 1'b0;
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
    end

endmodule

//--- test/tb_dma_arb.sv
`timescale 1ns/1ps

module tb_dma_arb;

    localparam int NR    = dma_arb_pkg::N_REGIONS;
    localparam int IDX_W = dma_arb_pkg::N_REGIONS_BITS;

    localparam logic [1:0] OP_NONE = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    localparam logic [1:0] OP_RD   = 2'd2;

    typedef struct packed {
        logic [3:0]  vmask;     // region_valid for this step.
        logic [3:0]  ctl;       // completion flag per region.
        logic        host_rdy;
        logic        card_rdy;
        logic        cdone;     // card_done pulse.
        logic [1:0]  reg_op;
        logic [1:0]  reg_addr;
        logic [31:0] reg_wdata;
    } step_t;

    localparam int N_STEPS        = 39;
    localparam int TIMEOUT_CYCLES = N_STEPS * 4 + 50;

    // vmask, ctl, host_ready, card_ready, card_done, register op, address, write data.
    localparam step_t STEPS [N_STEPS] = '{
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1001, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0011, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0100, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0001, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1111, 4'b0000, 1'b0, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1111, 4'b0000, 1'b1, 1'b0, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1010, 4'b1010, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0110, 4'b1111, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0101, 4'b0001, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0001, 4'b0001, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b1, OP_NONE, 2'd0, 32'h0},
        '{4'b0100, 4'b0100, 1'b1, 1'b1, 1'b1, OP_NONE, 2'd0, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b1, OP_NONE, 2'd0, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b1, OP_NONE, 2'd0, 32'h0},
        '{4'b1000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_RD, dma_arb_pkg::REG_GRANTS, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_RD, dma_arb_pkg::REG_CPLS, 32'h0},
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_WR, dma_arb_pkg::REG_ENABLE, 32'h5},
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b1010, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_RD, dma_arb_pkg::REG_ENABLE, 32'h0},
        '{4'b1111, 4'b0000, 1'b1, 1'b1, 1'b0, OP_WR, dma_arb_pkg::REG_GRANTS, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_RD, dma_arb_pkg::REG_GRANTS, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_RD, dma_arb_pkg::REG_CPLS, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_WR, dma_arb_pkg::REG_CPLS, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_RD, dma_arb_pkg::REG_CPLS, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_WR, dma_arb_pkg::REG_ENABLE, 32'hf},
        '{4'b1111, 4'b1111, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b1, OP_RD, dma_arb_pkg::REG_GRANTS, 32'h0},
        '{4'b0000, 4'b0000, 1'b1, 1'b1, 1'b0, OP_NONE, 2'd0, 32'h0}
    };

    logic                                              aclk;
    logic                                              aresetn;
    logic [NR-1:0]                                     region_valid;
    logic [NR-1:0]                                     region_ready;
    logic [NR-1:0]                                     region_done;
    dma_arb_pkg::dma_req_t [NR-1:0]                    region_req;
    logic                                              host_valid;
    dma_arb_pkg::dma_chan_req_t                        host_req;
    logic                                              host_ready;
    logic                                              host_done;
    logic                                              card_valid;
    dma_arb_pkg::dma_chan_req_t                        card_req;
    logic                                              card_ready;
    logic                                              card_done;
    logic                                              reg_valid;
    logic                                              reg_ready;
    dma_arb_pkg::reg_req_t                             reg_req;
    logic                                              rsp_valid;
    dma_arb_pkg::reg_rsp_t                             reg_rsp;

    // reference model state.
    int                   m_rr;
    logic [NR-1:0]        m_en;
    logic [IDX_W-1:0]     m_queue [$];  // regions waiting for a completion, oldest first.
    logic [31:0]          m_grants;
    logic [31:0]          m_cpls;
    logic [NR-1:0]        exp_done;
    logic                 exp_rsp_valid;
    logic [31:0]          exp_rdata;

    dma_arb_pkg::dma_req_t desc [NR];
    logic [14:0]           serial;
    int                    seed;
    int                    cycle_count;

    tb_clock_gen tb_clock_gen_inst (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    dma_arb_top #(
        .rd_wr (0)
    ) dma_arb_top_inst (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .region_valid (region_valid),
        .region_ready (region_ready),
        .region_done  (region_done),
        .region_req   (region_req),
        .host_valid   (host_valid),
        .host_req     (host_req),
        .host_ready   (host_ready),
        .host_done    (host_done),
        .card_valid   (card_valid),
        .card_req     (card_req),
        .card_ready   (card_ready),
        .card_done    (card_done),
        .reg_valid    (reg_valid),
        .reg_ready    (reg_ready),
        .reg_req      (reg_req),
        .rsp_valid    (rsp_valid),
        .reg_rsp      (reg_rsp)
    );

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // the serial number in the upper bits keeps every address distinct.
    task automatic refresh_desc(input int r);
        logic [31:0] rnd_host;
        logic [31:0] rnd_card;
        logic [31:0] rnd_len;
        rnd_host = $random(seed);
        rnd_card = $random(seed);
        rnd_len  = $random(seed);
        desc[r].paddr_host = {1'b0, serial, rnd_host};
        desc[r].paddr_card = {1'b1, serial, rnd_card};
        desc[r].len        = rnd_len[dma_arb_pkg::LEN_BITS-1:0];
        desc[r].ctl        = 1'b0;
        serial = serial + 15'd1;
    endtask

    task automatic check_registered_outputs();
        compare_value("region_done", 128'(region_done), 128'(exp_done));
        compare_value("reg_ready", 128'(reg_ready), 128'(1'b1));
        compare_value("rsp_valid", 128'(rsp_valid), 128'(exp_rsp_valid));
        if (exp_rsp_valid) begin
            compare_value("reg_rsp.rdata", 128'(reg_rsp.rdata), 128'(exp_rdata));
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge aclk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    initial begin
        step_t                      s;
        logic [NR-1:0]              active;
        logic [NR-1:0]              exp_ready;
        logic [IDX_W-1:0]           win;
        logic [IDX_W-1:0]           idx;
        logic [IDX_W-1:0]           head;
        logic                       found;
        logic                       accept;
        logic                       last_acc;
        logic [IDX_W-1:0]           last_win;
        logic                       cpl_evt;
        logic [31:0]                rd_val;
        dma_arb_pkg::dma_chan_req_t exp_host;
        dma_arb_pkg::dma_chan_req_t exp_card;

        region_valid = '0;
        region_req   = '0;
        host_ready   = 1'b0;
        host_done    = 1'b0;
        card_ready   = 1'b0;
        card_done    = 1'b0;
        reg_valid    = 1'b0;
        reg_req      = '0;

        seed          = 32'hfb10;
        serial        = '0;
        m_rr          = 0;
        m_en          = '1;  // all regions enabled after reset.
        m_grants      = '0;
        m_cpls        = '0;
        exp_done      = '0;
        exp_rsp_valid = 1'b0;
        exp_rdata     = '0;
        last_acc      = 1'b0;
        last_win      = '0;
        for (int r = 0; r < NR; r++) begin
            refresh_desc(r);
        end

        @(posedge aresetn);
        for (int i = 0; i < N_STEPS; i++) begin
            @(negedge aclk);
            check_registered_outputs();
            if (last_acc) begin
                refresh_desc(int'(last_win));  // the granted region brings a new descriptor.
            end

            s            = STEPS[i];
            region_valid = s.vmask;
            for (int r = 0; r < NR; r++) begin
                region_req[r]     = desc[r];
                region_req[r].ctl = s.ctl[r];
            end
            host_ready    = s.host_rdy;
            card_ready    = s.card_rdy;
            card_done     = s.cdone;
            reg_valid     = (s.reg_op != OP_NONE);
            reg_req.wr    = (s.reg_op == OP_WR);
            reg_req.addr  = s.reg_addr;
            reg_req.wdata = s.reg_wdata;
            #2;

            // first enabled valid region at or after rr wins.
            active = s.vmask & m_en;
            found  = 1'b0;
            win    = '0;
            for (int k = 0; k < NR; k++) begin
                idx = IDX_W'((m_rr + k) % NR);
                if (!found && active[idx]) begin
                    found = 1'b1;
                    win   = idx;
                end
            end
            accept = found && s.host_rdy && s.card_rdy &&
                     (m_queue.size() < dma_arb_pkg::CPL_DEPTH);

            exp_ready = '0;
            exp_ready[win] = accept;
            compare_value("region_ready", 128'(region_ready), 128'(exp_ready));
            compare_value("host_valid", 128'(host_valid), 128'(accept));
            compare_value("card_valid", 128'(card_valid), 128'(accept));
            if (accept) begin
                exp_host.paddr = desc[win].paddr_host;
                exp_host.len   = desc[win].len;
                exp_host.ctl   = s.ctl[win];
                exp_card.paddr = desc[win].paddr_card;
                exp_card.len   = desc[win].len;
                exp_card.ctl   = s.ctl[win];
                compare_value("host_req", 128'(host_req), 128'(exp_host));
                compare_value("card_req", 128'(card_req), 128'(exp_card));
            end

            // a read returns the register as it was before this edge.
            case (s.reg_addr)
                dma_arb_pkg::REG_ENABLE: rd_val = 32'(m_en);
                dma_arb_pkg::REG_GRANTS: rd_val = m_grants;
                dma_arb_pkg::REG_CPLS:   rd_val = m_cpls;
                default:                 rd_val = '0;
            endcase
            exp_rsp_valid = (s.reg_op == OP_RD);
            if (exp_rsp_valid) begin
                exp_rdata = rd_val;
            end

            exp_done = '0;
            cpl_evt  = s.cdone && (m_queue.size() > 0);
            if (cpl_evt) begin
                head = m_queue.pop_front();
                exp_done[head] = 1'b1;  // shows up one cycle after the pulse.
            end
            if (accept && s.ctl[win]) begin
                m_queue.push_back(win);
            end
            if (accept) begin
                m_rr = (m_rr + 1) % NR;
            end

            if (s.reg_op == OP_WR && s.reg_addr == dma_arb_pkg::REG_GRANTS) begin
                m_grants = '0;
            end else if (accept) begin
                m_grants = m_grants + 32'd1;
            end
            if (s.reg_op == OP_WR && s.reg_addr == dma_arb_pkg::REG_CPLS) begin
                m_cpls = '0;
            end else if (cpl_evt) begin
                m_cpls = m_cpls + 32'd1;
            end
            if (s.reg_op == OP_WR && s.reg_addr == dma_arb_pkg::REG_ENABLE) begin
                m_en = s.reg_wdata[NR-1:0];
            end

            last_acc = accept;
            last_win = win;
        end

        @(negedge aclk);
        check_registered_outputs();
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- vlog.f
src/dma_arb_pkg.sv
src/cpl_queue.sv
src/dma_rr_arbiter.sv
src/dma_arb_regs.sv
src/dma_arb_top.sv
test/tb_clock_gen.sv
test/tb_dma_arb.sv

//--- run.sh
#!/usr/bin/env bash
# Compiles the testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")"

LOG=sim.log
BUILD=obj_dir

verilator --binary --assert -Wno-fatal -j 0 --top-module tb_dma_arb \
    -f vlog.f --Mdir "$BUILD" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    echo "RESULT: FAIL"
    exit 1
fi

echo "RESULT: PASS"
exit 0
